//--- hdl/mipsConsts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath width
`define MIPS_XLEN 32

// general purpose registers
`define MIPS_NREGS 32

// register address width, log2 of MIPS_NREGS
`define MIPS_RADDRW 5

// jal link destination
`define MIPS_LINK_REG 5'd31

// stages from issue to write-back report: EX, MEM1, MEM2, WB
`define MIPS_PIPE_DEPTH 4

`endif

//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_e;

	// funct field of SPECIAL
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e funct;
	} rType_t;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iType_t;

	// one instruction word, two field layouts
	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instrWord_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} aluOp_e;

endpackage

`default_nettype wire

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;

	// write-back destination
	typedef enum logic [1:0] {
		DEST_RT   = 2'b00,
		DEST_RD   = 2'b01,
		DEST_LINK = 2'b10
	} destSel_e;

	// where an ID operand comes from
	typedef enum logic [1:0] {
		FWD_REG  = 2'b00,
		FWD_EX   = 2'b01,
		FWD_MEM1 = 2'b10,
		FWD_MEM2 = 2'b11
	} fwdSel_e;

	// EX result source
	typedef enum logic [1:0] {
		RES_ALU    = 2'b00,
		RES_PCLINK = 2'b01,
		RES_IMM    = 2'b10
	} resSrc_e;

endpackage

`default_nettype wire

//--- hdl/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module instrDecode (
	input  isaPkg::instrWord_u       instr,
	input  logic                     instrValid,
	output logic [`MIPS_RADDRW-1:0]  rs,
	output logic [`MIPS_RADDRW-1:0]  rt,
	output logic [`MIPS_RADDRW-1:0]  destAddr,
	output isaPkg::aluOp_e           aluOp,
	output logic                     useImm,
	output logic                     useShamt,
	output logic                     immZeroExt,
	output logic                     writesReg,
	output pipePkg::resSrc_e         resSrc,
	output logic [`MIPS_XLEN-1:0]    imm32,
	output logic [4:0]               shamt
);
	import isaPkg::*;
	import pipePkg::*;

	logic known;
	destSel_e destSel;

	assign rs = instr.iType.rs;
	assign rt = instr.iType.rt;
	assign shamt = instr.rType.shamt;
	assign writesReg = instrValid && known; // unknown encodings become bubbles

	always_comb begin
		aluOp = ALU_ADD;
		useImm = 1'b0;
		useShamt = 1'b0;
		immZeroExt = 1'b0;
		destSel = DEST_RT;
		resSrc = RES_ALU;
		known = 1'b1;
		case (instr.iType.opcode)
			OP_SPECIAL: begin
				destSel = DEST_RD;
				case (instr.rType.funct)
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_XOR:  aluOp = ALU_XOR;
					FN_NOR:  aluOp = ALU_NOR;
					FN_SLT:  aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					FN_SLL: begin
						aluOp = ALU_SLL;
						useShamt = 1'b1;
					end
					FN_SRL: begin
						aluOp = ALU_SRL;
						useShamt = 1'b1;
					end
					FN_SRA: begin
						aluOp = ALU_SRA;
						useShamt = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: useImm = 1'b1;
			OP_SLTI: begin
				aluOp = ALU_SLT;
				useImm = 1'b1;
			end
			OP_SLTIU: begin
				aluOp = ALU_SLTU; // compare against the sign-extended immediate
				useImm = 1'b1;
			end
			OP_ANDI: begin
				aluOp = ALU_AND;
				useImm = 1'b1;
				immZeroExt = 1'b1;
			end
			OP_ORI: begin
				aluOp = ALU_OR;
				useImm = 1'b1;
				immZeroExt = 1'b1;
			end
			OP_XORI: begin
				aluOp = ALU_XOR;
				useImm = 1'b1;
				immZeroExt = 1'b1;
			end
			OP_LUI: resSrc = RES_IMM; // value comes straight from imm32
			OP_JAL: begin
				resSrc = RES_PCLINK;
				destSel = DEST_LINK;
			end
			default: known = 1'b0;
		endcase
	end

	always_comb begin
		if (instr.iType.opcode == OP_LUI)
			imm32 = {instr.iType.imm16, 16'h0000};
		else if (immZeroExt)
			imm32 = {16'h0000, instr.iType.imm16};
		else
			imm32 = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
	end

	always_comb begin
		case (destSel)
			DEST_RT: destAddr = instr.iType.rt;
			DEST_RD: destAddr = instr.rType.rd;
			default: destAddr = `MIPS_LINK_REG;
		endcase
	end

	// operand A is either rs or shamt, operand B either rt or imm32
	assert final (!(useImm && useShamt))
		else $error("decode selected both immediate and shift amount");

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module regFile (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic [`MIPS_RADDRW-1:0] rdAddrA,
	input  logic [`MIPS_RADDRW-1:0] rdAddrB,
	input  logic                    wrEn,
	input  logic [`MIPS_RADDRW-1:0] wrAddr,
	input  logic [`MIPS_XLEN-1:0]   wrData,
	output logic [`MIPS_XLEN-1:0]   rdDataA,
	output logic [`MIPS_XLEN-1:0]   rdDataB
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
	logic wrLive;

	assign wrLive = wrEn && (wrAddr != '0); // r0 is never written

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `MIPS_NREGS; i++)
				regs[i] <= '0;
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// same-cycle write is visible to the readers
	assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

	regZeroA: assert property (@(posedge clk) disable iff (!rstN)
		rdAddrA == '0 |-> rdDataA == '0);
	regZeroB: assert property (@(posedge clk) disable iff (!rstN)
		rdAddrB == '0 |-> rdDataB == '0);

endmodule

`default_nettype wire

//--- hdl/operandFwd.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module operandFwd (
	input  logic [`MIPS_RADDRW-1:0] rs,
	input  logic [`MIPS_RADDRW-1:0] rt,
	input  logic [`MIPS_XLEN-1:0]   regA,
	input  logic [`MIPS_XLEN-1:0]   regB,
	input  logic                    useImm,
	input  logic                    useShamt,
	input  logic [`MIPS_XLEN-1:0]   imm32,
	input  logic [4:0]              shamt,
	input  logic                    exValid,
	input  logic [`MIPS_RADDRW-1:0] exDest,
	input  logic [`MIPS_XLEN-1:0]   exData,
	input  logic                    mem1Valid,
	input  logic [`MIPS_RADDRW-1:0] mem1Dest,
	input  logic [`MIPS_XLEN-1:0]   mem1Data,
	input  logic                    mem2Valid,
	input  logic [`MIPS_RADDRW-1:0] mem2Dest,
	input  logic [`MIPS_XLEN-1:0]   mem2Data,
	output logic [`MIPS_XLEN-1:0]   opA,
	output logic [`MIPS_XLEN-1:0]   opB,
	output logic [`MIPS_XLEN-1:0]   storeB
);
	import pipePkg::*;

	fwdSel_e fwdA;
	fwdSel_e fwdB;
	logic [`MIPS_XLEN-1:0] srcA;
	logic [`MIPS_XLEN-1:0] srcB;

	// youngest stage first, r0 never matches
	function automatic fwdSel_e pickSrc(input logic [`MIPS_RADDRW-1:0] addr);
		if (addr == '0)
			return FWD_REG;
		else if (exValid && exDest == addr)
			return FWD_EX;
		else if (mem1Valid && mem1Dest == addr)
			return FWD_MEM1;
		else if (mem2Valid && mem2Dest == addr)
			return FWD_MEM2;
		else
			return FWD_REG;
	endfunction

	function automatic logic [`MIPS_XLEN-1:0] fwdMux(input fwdSel_e sel,
			input logic [`MIPS_XLEN-1:0] regVal);
		case (sel)
			FWD_EX:   return exData;
			FWD_MEM1: return mem1Data;
			FWD_MEM2: return mem2Data;
			default:  return regVal;
		endcase
	endfunction

	always_comb begin
		fwdA = pickSrc(rs);
		fwdB = pickSrc(rt);
		srcA = fwdMux(fwdA, regA);
		srcB = fwdMux(fwdB, regB);
	end

	assign opA = useShamt ? {{(`MIPS_XLEN-5){1'b0}}, shamt} : srcA;
	assign opB = useImm ? imm32 : srcB;
	assign storeB = srcB; // rt value for a store stage

	assert final ((fwdA != FWD_EX || exValid) && (fwdB != FWD_EX || exValid) &&
			(fwdA != FWD_MEM1 || mem1Valid) && (fwdB != FWD_MEM1 || mem1Valid) &&
			(fwdA != FWD_MEM2 || mem2Valid) && (fwdB != FWD_MEM2 || mem2Valid))
		else $error("operand forwarded from an empty stage");

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module aluUnit (
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  isaPkg::aluOp_e        op,
	output logic [`MIPS_XLEN-1:0] y
);
	import isaPkg::*;

	logic [4:0] shAmt;
	logic sltBit;
	logic sltuBit;

	assign shAmt = a[4:0]; // shift amount rides on operand A
	assign sltBit = $signed(a) < $signed(b);
	assign sltuBit = a < b;

	always_comb begin
		case (op)
			ALU_ADD:
				y = a + b;
			ALU_SUB:
				y = a - b;
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_XOR:
				y = a ^ b;
			ALU_NOR:
				y = ~(a | b);
			ALU_SLT:
				y = {{(`MIPS_XLEN-1){1'b0}}, sltBit};
			ALU_SLTU:
				y = {{(`MIPS_XLEN-1){1'b0}}, sltuBit};
			ALU_SLL:
				y = b << shAmt;
			ALU_SRL:
				y = b >> shAmt;
			ALU_SRA:
				y = $unsigned($signed(b) >>> shAmt);
			ALU_LUI:
				y = b << 16;
			default:
				y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/exPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module exPipeline (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    instrValid,
	input  logic [`MIPS_XLEN-1:0]   instr,
	input  logic [`MIPS_XLEN-1:0]   pc,
	output logic                    wbValid,
	output logic [`MIPS_RADDRW-1:0] wbAddr,
	output logic [`MIPS_XLEN-1:0]   wbData
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`MIPS_RADDRW-1:0] idRs;
	logic [`MIPS_RADDRW-1:0] idRt;
	logic [`MIPS_RADDRW-1:0] idDest;
	aluOp_e idAluOp;
	logic idUseImm;
	logic idUseShamt;
	logic idWritesReg;
	resSrc_e idResSrc;
	logic [`MIPS_XLEN-1:0] idImm32;
	logic [4:0] idShamt;
	logic [`MIPS_XLEN-1:0] regA;
	logic [`MIPS_XLEN-1:0] regB;
	logic [`MIPS_XLEN-1:0] idOpA;
	logic [`MIPS_XLEN-1:0] idOpB;

	logic exValid;
	logic [`MIPS_XLEN-1:0] exOpA;
	logic [`MIPS_XLEN-1:0] exOpB;
	aluOp_e exAluOp;
	resSrc_e exResSrc;
	logic [`MIPS_XLEN-1:0] exImm32;
	logic [`MIPS_XLEN-1:0] exPc;
	logic [`MIPS_RADDRW-1:0] exDest;
	logic [`MIPS_XLEN-1:0] aluY;
	logic [`MIPS_XLEN-1:0] exData;

	logic mem1Valid;
	logic [`MIPS_RADDRW-1:0] mem1Dest;
	logic [`MIPS_XLEN-1:0] mem1Data;
	logic mem2Valid;
	logic [`MIPS_RADDRW-1:0] mem2Dest;
	logic [`MIPS_XLEN-1:0] mem2Data;

	instrDecode instrDecode_inst (
		.instr(instr), .instrValid(instrValid),
		.rs(idRs), .rt(idRt), .destAddr(idDest), .aluOp(idAluOp),
		.useImm(idUseImm), .useShamt(idUseShamt), .immZeroExt(),
		.writesReg(idWritesReg), .resSrc(idResSrc), .imm32(idImm32), .shamt(idShamt)
	);

	regFile regFile_inst (
		.clk(clk), .rstN(rstN),
		.rdAddrA(idRs), .rdAddrB(idRt),
		.wrEn(wbValid), .wrAddr(wbAddr), .wrData(wbData),
		.rdDataA(regA), .rdDataB(regB)
	);

	operandFwd operandFwd_inst (
		.rs(idRs), .rt(idRt), .regA(regA), .regB(regB),
		.useImm(idUseImm), .useShamt(idUseShamt), .imm32(idImm32), .shamt(idShamt),
		.exValid(exValid), .exDest(exDest), .exData(exData),
		.mem1Valid(mem1Valid), .mem1Dest(mem1Dest), .mem1Data(mem1Data),
		.mem2Valid(mem2Valid), .mem2Dest(mem2Dest), .mem2Data(mem2Data),
		.opA(idOpA), .opB(idOpB),
		.storeB() // no store path in this slice
	);

	aluUnit aluUnit_inst (.a(exOpA), .b(exOpB), .op(exAluOp), .y(aluY));

	always_comb begin
		case (exResSrc)
			RES_IMM:    exData = exImm32; // lui, already shifted
			RES_PCLINK: exData = exPc + `MIPS_XLEN'd8;
			default:    exData = aluY;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exValid <= 1'b0;
			mem1Valid <= 1'b0;
			mem2Valid <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			exValid <= instrValid && idWritesReg;
			mem1Valid <= exValid;
			mem2Valid <= mem1Valid;
			wbValid <= mem2Valid;
		end
	end

	always_ff @(posedge clk) begin
		exOpA <= idOpA;
		exOpB <= idOpB;
		exAluOp <= idAluOp;
		exResSrc <= idResSrc;
		exImm32 <= idImm32;
		exPc <= pc;
		exDest <= idDest;
		mem1Dest <= exDest;
		mem1Data <= exData;
		mem2Dest <= mem1Dest;
		mem2Data <= mem1Data;
		wbAddr <= mem2Dest;
		wbData <= mem2Data;
	end

endmodule

`default_nettype wire

//--- dv/mipsExSliceTable.svh
`ifndef MIPS_EX_SLICE_TABLE_SVH
`define MIPS_EX_SLICE_TABLE_SVH

	// immediate forms, results to rt
	addChecked("addiu r1", encodeI(OP_ADDIU, 0, 1, 16'h1234), 1, 32'h0000_1234);
	addChecked("addiu sign extend", encodeI(OP_ADDIU, 0, 2, 16'h8001), 2, 32'hffff_8001);
	addChecked("slti negative", encodeI(OP_SLTI, 2, 3, 16'h0005), 3, 32'h1);
	addChecked("sltiu large", encodeI(OP_SLTIU, 2, 4, 16'h0005), 4, 32'h0);
	addChecked("andi zero extend", encodeI(OP_ANDI, 2, 5, 16'hff0f), 5, 32'h0000_8001);
	addChecked("ori zero extend", encodeI(OP_ORI, 1, 6, 16'h8000), 6, 32'h0000_9234);
	addChecked("xori", encodeI(OP_XORI, 1, 7, 16'hffff), 7, 32'h0000_edcb);
	addChecked("lui", encodeI(OP_LUI, 0, 3, 16'hdead), 3, 32'hdead_0000);
	addChecked("sltiu all ones", encodeI(OP_SLTIU, 1, 4, 16'hffff), 4, 32'h1);

	// register forms, results to rd
	addChecked("addu", encodeR(FN_ADDU, 1, 2, 14, 0), 14, 32'hffff_9235);
	addChecked("subu", encodeR(FN_SUBU, 1, 6, 15, 0), 15, 32'hffff_8000);
	addChecked("and", encodeR(FN_AND, 2, 6, 16, 0), 16, 32'h0000_8000);
	addChecked("or", encodeR(FN_OR, 3, 7, 17, 0), 17, 32'hdead_edcb);
	addChecked("xor", encodeR(FN_XOR, 2, 5, 18, 0), 18, 32'hffff_0000);
	addChecked("nor", encodeR(FN_NOR, 1, 0, 19, 0), 19, 32'hffff_edcb);
	addChecked("slt signed", encodeR(FN_SLT, 2, 1, 20, 0), 20, 32'h1);
	addChecked("sltu unsigned", encodeR(FN_SLTU, 2, 1, 21, 0), 21, 32'h0);
	addChecked("sll by shamt", encodeR(FN_SLL, 0, 1, 22, 4), 22, 32'h0001_2340);
	addChecked("srl by shamt", encodeR(FN_SRL, 0, 3, 23, 8), 23, 32'h00de_ad00);
	addChecked("sra by shamt", encodeR(FN_SRA, 0, 3, 24, 8), 24, 32'hffde_ad00);
	addChecked("sra by 31", encodeR(FN_SRA, 0, 2, 25, 31), 25, 32'hffff_ffff);

	// forwarding chain on r26, youngest match wins
	addChecked("chain start", encodeI(OP_ADDIU, 0, 26, 16'h0001), 26, 32'h1);
	addChecked("fwd from ex", encodeI(OP_ADDIU, 26, 26, 16'h0002), 26, 32'h3);
	addChecked("fwd youngest", encodeI(OP_ADDIU, 26, 26, 16'h0004), 26, 32'h7);
	addChecked("fwd both operands", encodeR(FN_ADDU, 26, 26, 27, 0), 27, 32'he);
	addOpen("bubble", 1'b0, encodeI(OP_ADDIU, 0, 26, 16'h7777));
	addChecked("fwd mem1 and mem2", encodeR(FN_ADDU, 27, 26, 28, 0), 28, 32'h15);
	addOpen("unknown opcode", 1'b1, encodeI(6'h3f, 0, 26, 16'h5555));
	addOpen("unknown funct", 1'b1, encodeR(6'h3f, 1, 1, 26, 0));
	addChecked("read after writeback", encodeR(FN_ADDU, 26, 0, 29, 0), 29, 32'h7);

	// regfile bypass after three bubbles, source is in WB
	addChecked("bypass source", encodeI(OP_ADDIU, 0, 30, 16'h0055), 30, 32'h55);
	addOpen("bubble", 1'b0, 32'h0);
	addOpen("bubble", 1'b0, 32'h0);
	addOpen("bubble", 1'b0, 32'h0);
	addChecked("regfile bypass", encodeR(FN_ADDU, 30, 30, 14, 0), 14, 32'haa);

	// register zero
	addChecked("write r0", encodeI(OP_ADDIU, 0, 0, 16'h7fff), 0, 32'h0000_7fff);
	addChecked("r0 not forwarded", encodeR(FN_ADDU, 0, 1, 15, 0), 15, 32'h0000_1234);
	addOpen("bubble", 1'b0, 32'h0);
	addOpen("bubble", 1'b0, 32'h0);
	addChecked("r0 stays zero", encodeR(FN_ADDU, 0, 0, 16, 0), 16, 32'h0);

	// link and random operands, expected from the model
	addOpen("jal link", 1'b1, encodeJal(26'h0000040));
	addOpen("read link", 1'b1, encodeR(FN_ADDU, 31, 0, 17, 0));
	addOpen("addu random", 1'b1, encodeR(FN_ADDU, 8, 9, 18, 0));
	addOpen("subu random", 1'b1, encodeR(FN_SUBU, 10, 11, 19, 0));
	addOpen("sltu random", 1'b1, encodeR(FN_SLTU, 12, 13, 20, 0));
	addOpen("slt random", 1'b1, encodeR(FN_SLT, 12, 13, 21, 0));
	addOpen("srl random", 1'b1, encodeR(FN_SRL, 0, 8, 22, 3));
	addOpen("xor forwarded", 1'b1, encodeR(FN_XOR, 18, 19, 23, 0));

`endif

//--- dv/mipsExSliceTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsConsts.svh"

module mipsExSliceTb;
	import isaPkg::*;

	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic wbValid;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	// stimulus rows
	string rowName[$];
	logic rowValid[$];
	logic [31:0] rowWord[$];
	logic rowHasExp[$];
	logic [4:0] rowAddr[$];
	logic [31:0] rowData[$];
	logic rowBad[$];

	// rows in flight, oldest first
	int pendIdx[$];
	logic pendValid[$];
	logic [4:0] pendAddr[$];
	logic [31:0] pendData[$];

	logic [31:0] refRegs [32];
	integer seed;
	logic rowFail;
	int passCount = 0;
	int failCount = 0;
	int cycles = 0;
	int cycleLimit = 0;

	exPipeline exPipeline_inst (
		.clk(clk), .rstN(rstN),
		.instrValid(instrValid), .instr(instr), .pc(pc),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("timeout: run went past %0d cycles", cycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encodeJal(input logic [25:0] target);
		return {OP_JAL, target};
	endfunction

	task automatic addRow(input string name, input logic valid, input logic [31:0] word,
			input logic hasExp, input logic [4:0] addr, input logic [31:0] data);
		rowName.push_back(name);
		rowValid.push_back(valid);
		rowWord.push_back(word);
		rowHasExp.push_back(hasExp);
		rowAddr.push_back(addr);
		rowData.push_back(data);
	endtask

	task automatic addChecked(input string name, input logic [31:0] word,
			input logic [4:0] addr, input logic [31:0] data);
		addRow(name, 1'b1, word, 1'b1, addr, data);
	endtask

	task automatic addOpen(input string name, input logic valid, input logic [31:0] word);
		addRow(name, valid, word, 1'b0, 5'd0, 32'h0);
	endtask

	task automatic buildTable;
		int r;
		logic [31:0] rnd;
		for (r = 8; r < 14; r++) begin // random filler for r8..r13
			rnd = $random(seed);
			addOpen($sformatf("fill addiu r%0d", r), 1'b1, encodeI(OP_ADDIU, 0, r, rnd[15:0]));
			addOpen($sformatf("fill ori r%0d", r), 1'b1, encodeI(OP_ORI, r, r, rnd[31:16]));
		end
		`include "mipsExSliceTable.svh"
	endtask

	task automatic compareValue(input string sig, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: actual %h expected %h", sig, actual, expected);
			rowFail = 1'b1;
		end
	endtask

	// reference model of the ISA subset, reads refRegs in issue order
	task automatic predict(input logic valid, input logic [31:0] w, input logic [31:0] pcVal,
			output logic ok, output logic [4:0] addr, output logic [31:0] data);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [4:0] sh;
		a = refRegs[w[25:21]];
		b = refRegs[w[20:16]];
		sh = w[10:6];
		se = {{16{w[15]}}, w[15:0]};
		ze = {16'h0000, w[15:0]};
		ok = valid;
		addr = w[20:16];
		data = 32'h0;
		case (w[31:26])
			OP_SPECIAL: begin
				addr = w[15:11];
				case (w[5:0])
					FN_SLL:  data = b << sh;
					FN_SRL:  data = b >> sh;
					FN_SRA:  data = $signed(b) >>> sh;
					FN_ADDU: data = a + b;
					FN_SUBU: data = a - b;
					FN_AND:  data = a & b;
					FN_OR:   data = a | b;
					FN_XOR:  data = a ^ b;
					FN_NOR:  data = ~(a | b);
					FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
					FN_SLTU: data = (a < b) ? 32'h1 : 32'h0;
					default: ok = 1'b0;
				endcase
			end
			OP_ADDIU: data = a + se;
			OP_SLTI:  data = ($signed(a) < $signed(se)) ? 32'h1 : 32'h0;
			OP_SLTIU: data = (a < se) ? 32'h1 : 32'h0;
			OP_ANDI:  data = a & ze;
			OP_ORI:   data = a | ze;
			OP_XORI:  data = a ^ ze;
			OP_LUI:   data = {w[15:0], 16'h0000};
			OP_JAL: begin
				addr = 5'd31;
				data = pcVal + 32'd8; // link skips the delay slot
			end
			default: ok = 1'b0;
		endcase
	endtask

	task automatic issueRow(input int idx);
		logic ok;
		logic [4:0] a;
		logic [31:0] d;
		instrValid = rowValid[idx];
		instr = rowWord[idx];
		pc = 32'h0040_0000 + idx * 4;
		predict(rowValid[idx], rowWord[idx], pc, ok, a, d);
		rowFail = 1'b0;
		if (ok && a != 5'd0)
			refRegs[a] = d;
		if (rowHasExp[idx]) begin // table values must match the model
			compareValue("table wbAddr", {27'h0, rowAddr[idx]}, {27'h0, a});
			compareValue("table wbData", rowData[idx], d);
			a = rowAddr[idx];
			d = rowData[idx];
		end
		rowBad.push_back(rowFail);
		pendIdx.push_back(idx);
		pendValid.push_back(ok);
		pendAddr.push_back(a);
		pendData.push_back(d);
	endtask

	task automatic checkOldest;
		int idx;
		logic expV;
		logic [4:0] expA;
		logic [31:0] expD;
		idx = pendIdx.pop_front();
		expV = pendValid.pop_front();
		expA = pendAddr.pop_front();
		expD = pendData.pop_front();
		rowFail = rowBad[idx];
		if (expV && wbValid !== 1'b1) begin
			$display("%s: no write-back four cycles after issue", rowName[idx]);
			rowFail = 1'b1;
		end else if (!expV && wbValid !== 1'b0) begin
			$display("%s: write-back reported for an instruction that writes nothing",
				rowName[idx]);
			rowFail = 1'b1;
		end else if (expV) begin
			compareValue("wbAddr", {27'h0, wbAddr}, {27'h0, expA});
			compareValue("wbData", wbData, expD);
		end
		if (rowFail)
			failCount++;
		else
			passCount++;
		$display("%s: %s", rowName[idx], rowFail ? "failed" : "passed");
	endtask

	initial begin
		int n;
		int slot;
		seed = 74;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = 32'h0;
		pc = 32'h0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = 32'h0;
		buildTable();
		n = rowWord.size();
		cycleLimit = n + 5 + `MIPS_PIPE_DEPTH + 20;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (slot = 0; slot < n + `MIPS_PIPE_DEPTH; slot++) begin
			if (slot >= `MIPS_PIPE_DEPTH)
				checkOldest();
			if (slot < n) begin
				issueRow(slot);
			end else begin
				instrValid = 1'b0; // drain
				instr = 32'h0;
			end
			@(negedge clk);
		end
		$display("tests %0d, passed %0d, failed %0d", n, passCount, failCount);
		if (failCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsExSlice.f
+incdir+hdl
+incdir+dv
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/operandFwd.sv
hdl/aluUnit.sv
hdl/exPipeline.sv
dv/mipsExSliceTb.sv

//--- Bender.yml
package:
  name: mipsExSlice

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/instrDecode.sv
      - hdl/regFile.sv
      - hdl/operandFwd.sv
      - hdl/aluUnit.sv
      - hdl/exPipeline.sv
  - target: simulation
    include_dirs:
      - hdl
      - dv
    files:
      - dv/mipsExSliceTb.sv
